//--- src/audio_defs.svh
// Rate settings and derived divider terminal counts for the codec serial link
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

////////////////////////////////////////////////////////////
// Board and stream settings
////////////////////////////////////////////////////////////

// Board reference clock in Hz (18.432 MHz)
`define REF_CLK         18432000

// Codec sample rate in Hz
`define SAMPLE_RATE     48000

// Bits per channel word
`define DATA_WIDTH      16

// Left and right channel
`define CHANNEL_NUM     2

////////////////////////////////////////////////////////////
// Derived divider terminal counts
////////////////////////////////////////////////////////////

// Bit clock toggles every 6 reference cycles
`define BCK_DIV_LAST    ((`REF_CLK / (`SAMPLE_RATE * `DATA_WIDTH * `CHANNEL_NUM * 2)) - 1)

// Left/right clock toggles every 192 reference cycles
`define LRCK_DIV_LAST   ((`REF_CLK / (`SAMPLE_RATE * 2)) - 1)

`endif

//--- src/audio_pkg.sv
// Audio sample type, half-frame bit index type and DAC source-mode opcode
`include "audio_defs.svh"

package audio_pkg;

	////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////

	// One audio word as shifted on the codec data lines
	typedef logic [`DATA_WIDTH-1:0] sample_t;

	// Count of bits already shifted in the current half-frame
	// Wraps naturally after DATA_WIDTH bits
	typedef logic [$clog2(`DATA_WIDTH)-1:0] bit_idx_t;

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////

	// What the DAC plays in the next frame
	// Code 2'b11 is unassigned and illegal
	typedef enum logic [1:0] {
		// Zeros on both halves
		SRC_MUTE     = 2'b00,
		// External pulses word
		SRC_EXTERNAL = 2'b01,
		// Last published ADC word
		SRC_LOOPBACK = 2'b10
	} src_mode_e;

endpackage

//--- src/audio_clock_gen.sv
// Bit clock and left/right clock dividers, falling-edge strobes and shared bit index
`timescale 1ns/10ps
`include "audio_defs.svh"

module audio_clock_gen (
	input  logic                iCLK_18_4,
	input  logic                iRST_N,
	output logic                aud_bck,
	output logic                aud_lrck,
	output logic                aud_adclrck,
	output logic                bck_fall,
	output logic                lrck_fall,
	output audio_pkg::bit_idx_t bit_idx
);

	// Counter widths from the terminal counts
	localparam int BCK_CNT_W  = $clog2(`BCK_DIV_LAST + 1);
	localparam int LRCK_CNT_W = $clog2(`LRCK_DIV_LAST + 1);

	// Terminal counts sized to the counters
	localparam logic [BCK_CNT_W-1:0]  BCK_LAST  = BCK_CNT_W'(`BCK_DIV_LAST);
	localparam logic [LRCK_CNT_W-1:0] LRCK_LAST = LRCK_CNT_W'(`LRCK_DIV_LAST);

	logic [BCK_CNT_W-1:0]  bck_div;
	logic [LRCK_CNT_W-1:0] lrck_div;
	logic                  bck_wrap;
	logic                  lrck_wrap;

	////////////////////////////////////////////////////////////
	// Bit clock divider
	////////////////////////////////////////////////////////////

	// Last cycle of a bit clock half period
	assign bck_wrap = (bck_div == BCK_LAST);

	always_ff @(posedge iCLK_18_4 or negedge iRST_N) begin
		if (!iRST_N) begin
			bck_div <= '0;
			aud_bck <= 1'b0;
		end else if (bck_wrap) begin
			bck_div <= '0;
			aud_bck <= ~aud_bck;
		end else begin
			bck_div <= bck_div + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Left/right clock divider
	////////////////////////////////////////////////////////////

	// Last cycle of a half-frame
	assign lrck_wrap = (lrck_div == LRCK_LAST);

	// Shares its reset instant with the bit clock divider,
	// so each toggle lands on a bit clock fall
	always_ff @(posedge iCLK_18_4 or negedge iRST_N) begin
		if (!iRST_N) begin
			lrck_div <= '0;
			aud_lrck <= 1'b0;
		end else if (lrck_wrap) begin
			lrck_div <= '0;
			aud_lrck <= ~aud_lrck;
		end else begin
			lrck_div <= lrck_div + 1'b1;
		end
	end

	// ADC side framed by the same clock
	assign aud_adclrck = aud_lrck;

	////////////////////////////////////////////////////////////
	// Edge strobes
	////////////////////////////////////////////////////////////

	// High in the cycle whose closing edge drops the register
	assign bck_fall  = bck_wrap & aud_bck;
	assign lrck_fall = lrck_wrap & aud_lrck;

	////////////////////////////////////////////////////////////
	// Shared bit index
	////////////////////////////////////////////////////////////

	// 16 falls per half-frame, so the index is back at 0
	// on every left/right edge without an explicit clear
	always_ff @(posedge iCLK_18_4 or negedge iRST_N) begin
		if (!iRST_N) begin
			bit_idx <= '0;
		end else if (bck_fall) begin
			bit_idx <= bit_idx + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Strobe width of one cycle
	a_bck_fall_single: assert property (
		@(posedge iCLK_18_4) disable iff (!iRST_N)
		bck_fall |=> !bck_fall
	) else $error("bck_fall high on two consecutive cycles");

	// Frame edges aligned to bit clock falls
	a_lrck_on_bck: assert property (
		@(posedge iCLK_18_4) disable iff (!iRST_N)
		lrck_fall |-> bck_fall
	) else $error("lrck_fall without bck_fall");

endmodule

//--- src/dac_serializer.sv
// DAC source selection, per-frame word latch and MSB-first serial output
`timescale 1ns/10ps

module dac_serializer (
	input  logic                 iCLK_18_4,
	input  logic                 iRST_N,
	input  logic                 bck_fall,
	input  logic                 lrck_fall,
	input  audio_pkg::bit_idx_t  bit_idx,
	input  audio_pkg::src_mode_e src_mode,
	input  audio_pkg::sample_t   pulses,
	input  audio_pkg::sample_t   loop_word,
	output logic                 aud_data
);

	// Word chosen by the opcode
	audio_pkg::sample_t  src_word;
	// Word playing in the current frame
	audio_pkg::sample_t  frame_word;
	// Word valid after the coming edge
	audio_pkg::sample_t  word_next;
	// Index after the coming bit clock fall
	audio_pkg::bit_idx_t next_idx;

	////////////////////////////////////////////////////////////
	// Source decode
	////////////////////////////////////////////////////////////

	always_comb begin
		case (src_mode)
			audio_pkg::SRC_MUTE: begin
				src_word = '0;
			end
			audio_pkg::SRC_EXTERNAL: begin
				src_word = pulses;
			end
			audio_pkg::SRC_LOOPBACK: begin
				src_word = loop_word;
			end
			default: begin
				// Illegal code plays silence
				src_word = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Frame word latch
	////////////////////////////////////////////////////////////

	// Loaded once per frame, held through low and high halves
	always_ff @(posedge iCLK_18_4 or negedge iRST_N) begin
		if (!iRST_N) begin
			frame_word <= '0;
		end else if (lrck_fall) begin
			frame_word <= src_word;
		end
	end

	// New word must be visible at the same edge it is latched
	assign word_next = lrck_fall ? src_word : frame_word;

	////////////////////////////////////////////////////////////
	// Serial output
	////////////////////////////////////////////////////////////

	// Truncates to the index width, 15 wraps to 0
	assign next_idx = bit_idx + 1'b1;

	// Bit 15 leaves at each left/right edge (left-justified)
	// Data changes with the bit clock fall, stable at the rise
	always_ff @(posedge iCLK_18_4 or negedge iRST_N) begin
		if (!iRST_N) begin
			aud_data <= 1'b0;
		end else if (bck_fall) begin
			aud_data <= word_next[~next_idx];
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Opcode sampled only at frame start
	a_src_mode_legal: assert property (
		@(posedge iCLK_18_4) disable iff (!iRST_N)
		lrck_fall |-> (src_mode inside {audio_pkg::SRC_MUTE,
			audio_pkg::SRC_EXTERNAL, audio_pkg::SRC_LOOPBACK})
	) else $error("illegal src_mode at lrck_fall");

endmodule

//--- src/adc_deserializer.sv
// ADC serial capture into a shift word and per-frame publication on linein
`timescale 1ns/10ps

module adc_deserializer (
	input  logic                iCLK_18_4,
	input  logic                iRST_N,
	input  logic                bck_fall,
	input  logic                lrck_fall,
	input  audio_pkg::bit_idx_t bit_idx,
	input  logic                aud_adcdat,
	output audio_pkg::sample_t  linein,
	output logic                linein_valid
);

	// Word under assembly
	audio_pkg::sample_t cap_word;
	// Same word with this cycle's bit merged in
	audio_pkg::sample_t cap_next;

	////////////////////////////////////////////////////////////
	// Bit capture
	////////////////////////////////////////////////////////////

	// MSB first, position 15 minus bits already taken
	always_comb begin
		cap_next = cap_word;
		if (bck_fall) begin
			cap_next[~bit_idx] = aud_adcdat;
		end
	end

	// Partial word held between bit clock falls
	always_ff @(posedge iCLK_18_4 or negedge iRST_N) begin
		if (!iRST_N) begin
			cap_word <= '0;
		end else begin
			cap_word <= cap_next;
		end
	end

	////////////////////////////////////////////////////////////
	// Publication
	////////////////////////////////////////////////////////////

	// High half ends at lrck_fall
	// Its last bit arrives in that same cycle, hence cap_next
	always_ff @(posedge iCLK_18_4 or negedge iRST_N) begin
		if (!iRST_N) begin
			linein <= '0;
		end else if (lrck_fall) begin
			linein <= cap_next;
		end
	end

	// One-cycle strobe alongside the new linein
	always_ff @(posedge iCLK_18_4 or negedge iRST_N) begin
		if (!iRST_N) begin
			linein_valid <= 1'b0;
		end else begin
			linein_valid <= lrck_fall;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// linein moves only together with its valid strobe
	a_linein_with_valid: assert property (
		@(posedge iCLK_18_4) disable iff (!iRST_N)
		(linein != $past(linein)) |-> linein_valid
	) else $error("linein changed without linein_valid");

endmodule

//--- src/audio_codec_if.sv
// Top level joining the clock generator, DAC serializer and ADC deserializer
`timescale 1ns/10ps

module audio_codec_if (
	input  logic                 iCLK_18_4,
	input  logic                 iRST_N,
	// Sample and control
	input  audio_pkg::sample_t   pulses,
	input  audio_pkg::src_mode_e src_mode,
	// Captured ADC word
	output audio_pkg::sample_t   linein,
	output logic                 linein_valid,
	// Codec pins
	output logic                 aud_bck,
	output logic                 aud_lrck,
	output logic                 aud_adclrck,
	output logic                 aud_data,
	input  logic                 aud_adcdat
);

	// Strobes and index from the clock generator
	logic                bck_fall;
	logic                lrck_fall;
	audio_pkg::bit_idx_t bit_idx;

	////////////////////////////////////////////////////////////
	// Clocks and strobes
	////////////////////////////////////////////////////////////

	audio_clock_gen u_clock_gen (
		.iCLK_18_4   (iCLK_18_4),
		.iRST_N      (iRST_N),
		.aud_bck     (aud_bck),
		.aud_lrck    (aud_lrck),
		.aud_adclrck (aud_adclrck),
		.bck_fall    (bck_fall),
		.lrck_fall   (lrck_fall),
		.bit_idx     (bit_idx)
	);

	////////////////////////////////////////////////////////////
	// Shifters
	////////////////////////////////////////////////////////////

	// Loopback takes linein before it is replaced at lrck_fall
	dac_serializer u_dac (
		.iCLK_18_4 (iCLK_18_4),
		.iRST_N    (iRST_N),
		.bck_fall  (bck_fall),
		.lrck_fall (lrck_fall),
		.bit_idx   (bit_idx),
		.src_mode  (src_mode),
		.pulses    (pulses),
		.loop_word (linein),
		.aud_data  (aud_data)
	);

	adc_deserializer u_adc (
		.iCLK_18_4    (iCLK_18_4),
		.iRST_N       (iRST_N),
		.bck_fall     (bck_fall),
		.lrck_fall    (lrck_fall),
		.bit_idx      (bit_idx),
		.aud_adcdat   (aud_adcdat),
		.linein       (linein),
		.linein_valid (linein_valid)
	);

endmodule

//--- tb/tb_audio_codec_if.sv
// Testbench for the codec interface: clock, reset, codec model, directed tests, watchdog
`timescale 1ns/10ps
`include "audio_defs.svh"

module tb_audio_codec_if;

	// Timing expected from the divider settings
	localparam int CLK_PERIOD = 10;
	localparam int BCK_HALF   = `BCK_DIV_LAST + 1;
	localparam int LRCK_HALF  = `LRCK_DIV_LAST + 1;
	localparam int HALF_BITS  = LRCK_HALF / (2 * BCK_HALF);
	// 20 frames per test
	localparam int NUM_TESTS  = 6;
	localparam longint TIMEOUT_NS = 64'd20 * 2 * LRCK_HALF * CLK_PERIOD * NUM_TESTS;

	logic                 iCLK_18_4;
	logic                 iRST_N;
	audio_pkg::sample_t   pulses;
	audio_pkg::src_mode_e src_mode;
	audio_pkg::sample_t   linein;
	logic                 linein_valid;
	logic                 aud_bck;
	logic                 aud_lrck;
	logic                 aud_adclrck;
	logic                 aud_data;
	logic                 aud_adcdat;

	integer seed = 32'h73cef216;

	// Codec model state
	audio_pkg::sample_t adc_tx_q[$];
	audio_pkg::sample_t rx_word_q[$];
	logic               rx_lr_q[$];
	audio_pkg::sample_t rx_shift = '0;
	logic               rx_lr = 1'b0;
	int                 rx_cnt = 0;
	audio_pkg::sample_t tx_word = '0;
	logic               tx_active = 1'b0;
	int                 tx_cnt = 0;

	audio_codec_if u_audio_codec_if (
		.iCLK_18_4    (iCLK_18_4),
		.iRST_N       (iRST_N),
		.pulses       (pulses),
		.src_mode     (src_mode),
		.linein       (linein),
		.linein_valid (linein_valid),
		.aud_bck      (aud_bck),
		.aud_lrck     (aud_lrck),
		.aud_adclrck  (aud_adclrck),
		.aud_data     (aud_data),
		.aud_adcdat   (aud_adcdat)
	);

	initial iCLK_18_4 = 1'b0;
	always #(CLK_PERIOD / 2) iCLK_18_4 = ~iCLK_18_4;

	////////////////////////////////////////////////////////////
	// Codec model
	////////////////////////////////////////////////////////////

	// DAC bits taken at each bit clock rise, ADC bits driven just after it
	always @(posedge aud_bck or negedge iRST_N) begin
		if (!iRST_N) begin
			rx_cnt = 0;
			rx_lr = 1'b0;
			tx_active = 1'b0;
			aud_adcdat <= 1'b0;
		end else begin
			// New half starts on a level change
			if (aud_lrck !== rx_lr) begin
				rx_lr = aud_lrck;
				rx_cnt = 0;
			end
			rx_shift = {rx_shift[`DATA_WIDTH-2:0], aud_data};
			rx_cnt++;
			if (rx_cnt == `DATA_WIDTH) begin
				rx_word_q.push_back(rx_shift);
				rx_lr_q.push_back(rx_lr);
				rx_cnt = 0;
			end
			// ADC words go out in the high half only, zeros when the queue is empty
			if (aud_lrck === 1'b1) begin
				if (!tx_active) begin
					tx_active = 1'b1;
					tx_cnt = 0;
					tx_word = (adc_tx_q.size() > 0) ? adc_tx_q.pop_front() : '0;
				end
				aud_adcdat <= #1 tx_word[`DATA_WIDTH - 1 - tx_cnt];
				tx_cnt++;
			end else begin
				tx_active = 1'b0;
				aud_adcdat <= #1 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Compare and helper tasks
	////////////////////////////////////////////////////////////

	task automatic report_failure();
		$display("Test failures found");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_sample(input string name, input audio_pkg::sample_t got,
		input audio_pkg::sample_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
			report_failure();
		end
	endtask

	function automatic audio_pkg::sample_t rand_word();
		return audio_pkg::sample_t'($random(seed));
	endfunction

	// Mode and word change 1 ns after a clock edge
	task automatic drive_source(input audio_pkg::src_mode_e mode, input audio_pkg::sample_t word);
		@(posedge iCLK_18_4);
		#1;
		src_mode = mode;
		pulses = word;
		@(negedge iCLK_18_4);
	endtask

	// Returns linein as it was just before the next lrck fall
	task automatic wait_frame_start(output audio_pkg::sample_t prev_linein);
		prev_linein = linein;
		while (aud_lrck !== 1'b1) @(negedge iCLK_18_4);
		while (aud_lrck === 1'b1) begin
			prev_linein = linein;
			@(negedge iCLK_18_4);
		end
		// Older halves belong to the previous frame
		rx_word_q.delete();
		rx_lr_q.delete();
	endtask

	task automatic collect_frame(output audio_pkg::sample_t low_word,
		output audio_pkg::sample_t high_word);
		while (rx_word_q.size() < 2) @(negedge iCLK_18_4);
		check_count("aud_lrck of first half", rx_lr_q.pop_front(), 0);
		check_count("aud_lrck of second half", rx_lr_q.pop_front(), 1);
		low_word = rx_word_q.pop_front();
		high_word = rx_word_q.pop_front();
	endtask

	task automatic wait_valid();
		@(negedge iCLK_18_4);
		while (linein_valid !== 1'b1) @(negedge iCLK_18_4);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_clock_timing();
		time  t0;
		int   rises;
		logic level;
		logic prev_bck;
		@(posedge aud_bck);
		t0 = $time;
		@(negedge aud_bck);
		check_count("aud_bck high cycles", int'(($time - t0) / CLK_PERIOD), BCK_HALF);
		t0 = $time;
		@(posedge aud_bck);
		check_count("aud_bck low cycles", int'(($time - t0) / CLK_PERIOD), BCK_HALF);
		@(posedge aud_lrck);
		t0 = $time;
		@(negedge aud_lrck);
		check_count("aud_lrck high cycles", int'(($time - t0) / CLK_PERIOD), LRCK_HALF);
		t0 = $time;
		@(posedge aud_lrck);
		check_count("aud_lrck low cycles", int'(($time - t0) / CLK_PERIOD), LRCK_HALF);
		// One full frame, sampled mid-cycle
		for (int h = 0; h < 2; h++) begin
			@(negedge iCLK_18_4);
			level = aud_lrck;
			prev_bck = aud_bck;
			rises = 0;
			while (aud_lrck === level) begin
				if (aud_bck && !prev_bck)
					rises++;
				prev_bck = aud_bck;
				check_count("aud_adclrck", aud_adclrck, aud_lrck);
				@(negedge iCLK_18_4);
			end
			check_count("aud_bck rises per half", rises, HALF_BITS);
		end
	endtask

	task automatic test_external_play();
		audio_pkg::sample_t word;
		audio_pkg::sample_t prev;
		audio_pkg::sample_t low_word;
		audio_pkg::sample_t high_word;
		for (int i = 0; i < 4; i++) begin
			word = rand_word();
			drive_source(audio_pkg::SRC_EXTERNAL, word);
			wait_frame_start(prev);
			collect_frame(low_word, high_word);
			check_sample("aud_data low half", low_word, word);
			check_sample("aud_data high half", high_word, word);
		end
	endtask

	task automatic test_mute();
		audio_pkg::sample_t prev;
		audio_pkg::sample_t low_word;
		audio_pkg::sample_t high_word;
		for (int i = 0; i < 2; i++) begin
			// Nonzero pulses must not leak through
			drive_source(audio_pkg::SRC_MUTE, rand_word() | audio_pkg::sample_t'(1));
			wait_frame_start(prev);
			collect_frame(low_word, high_word);
			check_sample("aud_data low half", low_word, '0);
			check_sample("aud_data high half", high_word, '0);
		end
	endtask

	task automatic test_adc_capture();
		audio_pkg::sample_t sent[4];
		int                 width;
		// Next high half is the first one taken from the queue
		wait_valid();
		for (int i = 0; i < 4; i++) begin
			sent[i] = rand_word();
			adc_tx_q.push_back(sent[i]);
		end
		for (int i = 0; i < 4; i++) begin
			wait_valid();
			check_sample("linein", linein, sent[i]);
			width = 0;
			while (linein_valid === 1'b1) begin
				width++;
				@(negedge iCLK_18_4);
			end
			check_count("linein_valid width", width, 1);
		end
	endtask

	task automatic test_loopback();
		audio_pkg::sample_t sent[4];
		audio_pkg::sample_t prev;
		audio_pkg::sample_t low_word;
		audio_pkg::sample_t high_word;
		drive_source(audio_pkg::SRC_LOOPBACK, rand_word());
		// Words queued in a low half go out from the next high half on
		wait_valid();
		for (int i = 0; i < 4; i++) begin
			sent[i] = rand_word();
			adc_tx_q.push_back(sent[i]);
		end
		// This frame still plays the word from before the queue was filled
		wait_frame_start(prev);
		for (int i = 0; i < 4; i++) begin
			// Captured in one frame, played from the start of the next
			wait_frame_start(prev);
			check_sample("linein before frame start", prev, sent[i]);
			collect_frame(low_word, high_word);
			check_sample("aud_data low half", low_word, sent[i]);
			check_sample("aud_data high half", high_word, sent[i]);
		end
	endtask

	task automatic test_reset_midframe();
		audio_pkg::sample_t word;
		audio_pkg::sample_t adc_word;
		audio_pkg::sample_t prev;
		audio_pkg::sample_t low_word;
		audio_pkg::sample_t high_word;
		// All-ones frame keeps aud_data high up to the reset
		drive_source(audio_pkg::SRC_EXTERNAL, '1);
		// Nonzero capture so a cleared linein shows
		adc_word = rand_word() | audio_pkg::sample_t'(1);
		while (aud_lrck !== 1'b0) @(negedge iCLK_18_4);
		adc_tx_q.push_back(adc_word);
		wait_valid();
		check_sample("linein", linein, adc_word);
		// Early in the high half, bit clock high
		repeat (LRCK_HALF + BCK_HALF) @(posedge iCLK_18_4);
		#1;
		iRST_N = 1'b0;
		@(negedge iCLK_18_4);
		check_count("aud_bck", aud_bck, 0);
		check_count("aud_lrck", aud_lrck, 0);
		check_count("aud_data", aud_data, 0);
		check_count("linein_valid", linein_valid, 0);
		check_sample("linein", linein, '0);
		@(posedge iCLK_18_4);
		#1;
		iRST_N = 1'b1;
		word = rand_word();
		drive_source(audio_pkg::SRC_EXTERNAL, word);
		wait_frame_start(prev);
		collect_frame(low_word, high_word);
		check_sample("aud_data low half", low_word, word);
		check_sample("aud_data high half", high_word, word);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		iRST_N = 1'b0;
		pulses = '0;
		src_mode = audio_pkg::SRC_MUTE;
		aud_adcdat = 1'b0;
		repeat (2) @(posedge iCLK_18_4);
		#1;
		iRST_N = 1'b1;
		test_clock_timing();
		test_external_play();
		test_mute();
		test_adc_capture();
		test_loopback();
		test_reset_midframe();
		$display("All tests passed!");
		$finish;
	end

	// Bound on the whole run
	initial begin
		#(TIMEOUT_NS);
		$display("Timed out: the tests did not finish within %0d ns", TIMEOUT_NS);
		report_failure();
	end

endmodule

//--- src.f
+incdir+src
src/audio_pkg.sv
src/audio_clock_gen.sv
src/dac_serializer.sv
src/adc_deserializer.sv
src/audio_codec_if.sv
tb/tb_audio_codec_if.sv
